// File: mips_control.f
verilog/mips_control_pkg.sv
verilog/main_decoder.sv
verilog/alu_control.sv
verilog/mips_control.sv
testbench/control_checker.sv
testbench/tb_mips_control.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_mips_control
FILELIST  := mips_control.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_mips_control.sv
`default_nettype none

module tb_mips_control
   import mips_control_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLOCK_PERIOD = 10;
   localparam int N_DIRECTED   = 4;
   localparam int N_RANDOM     = 2000;
   localparam int END_TIMEOUT  = 20;   // Cycles

   logic        clock = 1'b0;
   logic        soft_reset;
   instr_t      instruction;
   logic        reg_dst;
   logic        reg_write;
   logic        alu_src;
   logic        mem_read;
   logic        mem_write;
   logic        mem_to_reg;
   alu_op_t     alu_op;
   alu_ctrl_t   alu_ctrl;
   logic [31:0] error_count;
   logic [31:0] flag_checks;
   logic [31:0] alu_checks;

   integer      seed;
   int          end_wait;
   logic        timed_out;
   instr_t      next_word;

   ////////////////////////////////////////
   // Instruction table for stimulus
   ////////////////////////////////////////

   field_t funct_list [15] = '{
      FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
      FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_JR, FN_JALR
   };

   field_t opcode_list [19] = '{
      OP_LB, OP_LH, OP_LW, OP_LWU, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW,
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI,
      OP_BEQ, OP_BNE, OP_J, OP_JAL
   };

   instr_t directed [N_DIRECTED] = '{
      {OP_RTYPE, 20'd0, 6'd15},   // Function 15 must not look like LUI
      {6'd63, 26'd0},
      {OP_LUI, 26'd0},
      {OP_RTYPE, 20'd0, FN_JR}
   };

   always #(CLOCK_PERIOD / 2) clock = ~clock;

   mips_control i_mips_control (
      .i_clock       (clock),
      .i_soft_reset  (soft_reset),
      .i_instruction (instruction),
      .o_reg_dst     (reg_dst),
      .o_reg_write   (reg_write),
      .o_alu_src     (alu_src),
      .o_mem_read    (mem_read),
      .o_mem_write   (mem_write),
      .o_mem_to_reg  (mem_to_reg),
      .o_alu_op      (alu_op),
      .o_alu_ctrl    (alu_ctrl)
   );

   control_checker u_control_checker (
      .i_clock       (clock),
      .i_soft_reset  (soft_reset),
      .i_instruction (instruction),
      .i_reg_dst     (reg_dst),
      .i_reg_write   (reg_write),
      .i_alu_src     (alu_src),
      .i_mem_read    (mem_read),
      .i_mem_write   (mem_write),
      .i_mem_to_reg  (mem_to_reg),
      .i_alu_op      (alu_op),
      .i_alu_ctrl    (alu_ctrl),
      .o_error_count (error_count),
      .o_flag_checks (flag_checks),
      .o_alu_checks  (alu_checks)
   );

   // 60% table entries, 20% opcode 0 with any function, 20% raw words
   task automatic next_instruction(output instr_t word);
      logic [31:0] body;
      int          kind;
      int          pick;
      body = $random(seed);
      kind = int'($unsigned($random(seed)) % 100);
      if (kind < 60)
      begin
         pick = int'($unsigned($random(seed)) % 34);
         if (pick < 15)
            word = {OP_RTYPE, body[25:6], funct_list[pick]};
         else
            word = {opcode_list[pick - 15], body[25:0]};
      end
      else if (kind < 80)
         word = {OP_RTYPE, body[25:0]};
      else
         word = body;
   endtask

   initial
   begin
      seed        = 34796;
      soft_reset  = 1'b0;
      instruction = '0;
      timed_out   = 1'b0;
      end_wait    = 0;
      repeat (3) @(negedge clock);
      soft_reset = 1'b1;
      for (int i = 0; i < N_DIRECTED; i++)
      begin
         instruction = directed[i];
         @(negedge clock);
      end
      for (int i = 0; i < N_RANDOM; i++)
      begin
         next_instruction(next_word);
         instruction = next_word;
         @(negedge clock);
      end

      // Last ALU check lands one cycle after the last drive
      while (alu_checks < 32'(N_DIRECTED + N_RANDOM) && end_wait < END_TIMEOUT)
      begin
         @(posedge clock);
         end_wait++;
      end
      if (alu_checks < 32'(N_DIRECTED + N_RANDOM))
      begin
         $display("Timed out waiting for the checker to finish the ALU output checks");
         timed_out = 1'b1;
      end

      $display("Checks: %0d flag, %0d ALU; errors: %0d", flag_checks, alu_checks,
               error_count);
      if (error_count == 0 && !timed_out)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/control_checker.sv
`default_nettype none

module control_checker
   import mips_control_pkg::*;
   (
      input  wire         i_clock,
      input  wire         i_soft_reset,
      input  wire instr_t i_instruction,
      input  wire         i_reg_dst,
      input  wire         i_reg_write,
      input  wire         i_alu_src,
      input  wire         i_mem_read,
      input  wire         i_mem_write,
      input  wire         i_mem_to_reg,
      input  wire [1:0]   i_alu_op,
      input  wire [3:0]   i_alu_ctrl,
      output logic [31:0] o_error_count,
      output logic [31:0] o_flag_checks,
      output logic [31:0] o_alu_checks
   );

   timeunit 1ns;
   timeprecision 1ps;

   localparam int SAMPLE_DELAY  = 2;    // After the falling-edge drive
   localparam int RESET_TIMEOUT = 20;   // Cycles

   int          error_count  = 0;
   int          other_errors = 0;
   int          flag_checks  = 0;
   int          alu_checks   = 0;
   int          reset_checks = 0;
   int          reset_wait   = 0;
   logic        seen_edge    = 1'b0;
   instr_t      last_instr;              // Instruction at the last rising edge
   logic        last_reset;
   logic [11:0] now_row;
   logic [11:0] last_row;

   assign o_error_count = 32'(error_count + other_errors);
   assign o_flag_checks = 32'(flag_checks);
   assign o_alu_checks  = 32'(alu_checks);

   ////////////////////////////////////////
   // Reference table
   ////////////////////////////////////////

   // Row is {reg_dst, reg_write, alu_src, mem_read, mem_write, mem_to_reg, class, code}
   function automatic logic [11:0] table_row(input instr_t instr);
      field_t      opcode;
      field_t      funct;
      logic [11:0] row;
      opcode = instr[31:26];
      funct  = instr[5:0];
      row    = {6'b000000, ALUOP_MEM, ALU_ADD};
      case (opcode)
         OP_RTYPE:
         begin
            case (funct)
               FN_SLL:  row = {6'b111000, ALUOP_ARITH, ALU_SLL};
               FN_SRL:  row = {6'b111000, ALUOP_ARITH, ALU_SRL};
               FN_SRA:  row = {6'b111000, ALUOP_ARITH, ALU_SRA};
               FN_SLLV: row = {6'b110000, ALUOP_ARITH, ALU_SLL};
               FN_SRLV: row = {6'b110000, ALUOP_ARITH, ALU_SRL};
               FN_SRAV: row = {6'b110000, ALUOP_ARITH, ALU_SRA};
               FN_ADDU: row = {6'b110000, ALUOP_ARITH, ALU_ADD};
               FN_SUBU: row = {6'b110000, ALUOP_ARITH, ALU_SUB};
               FN_AND:  row = {6'b110000, ALUOP_ARITH, ALU_AND};
               FN_OR:   row = {6'b110000, ALUOP_ARITH, ALU_OR};
               FN_XOR:  row = {6'b110000, ALUOP_ARITH, ALU_XOR};
               FN_NOR:  row = {6'b110000, ALUOP_ARITH, ALU_NOR};
               FN_SLT:  row = {6'b110000, ALUOP_ARITH, ALU_SLT};
               FN_JR:   row = {6'b000000, ALUOP_BRANCH, ALU_SUB};
               FN_JALR: row = {6'b110000, ALUOP_BRANCH, ALU_SUB};
               default: row = {6'b000000, ALUOP_MEM, ALU_ADD};
            endcase
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
            row = {6'b011101, ALUOP_MEM, ALU_ADD};
         OP_SB, OP_SH, OP_SW:
            row = {6'b001010, ALUOP_MEM, ALU_ADD};
         OP_ADDI: row = {6'b011000, ALUOP_ARITH, ALU_ADD};
         OP_ANDI: row = {6'b011000, ALUOP_ARITH, ALU_AND};
         OP_ORI:  row = {6'b011000, ALUOP_ARITH, ALU_OR};
         OP_XORI: row = {6'b011000, ALUOP_ARITH, ALU_XOR};
         OP_SLTI: row = {6'b011000, ALUOP_ARITH, ALU_SLT};
         OP_LUI:  row = {6'b011000, ALUOP_MEM, ALU_LUI};
         OP_BEQ, OP_BNE:
            row = {6'b001000, ALUOP_BRANCH, ALU_SUB};
         OP_J:    row = {6'b000000, ALUOP_BRANCH, ALU_SUB};
         OP_JAL:  row = {6'b010000, ALUOP_BRANCH, ALU_SUB};
         default: row = {6'b000000, ALUOP_MEM, ALU_ADD};
      endcase
      return row;
   endfunction

   task automatic compare_value(input string name, input logic [3:0] expected,
                                input logic [3:0] actual, input instr_t instr);
      if (actual !== expected)
      begin
         error_count++;
         $display("[ERROR] %s expected %h got %h (instruction %h, time %0t)",
                  name, expected, actual, instr, $time);
      end
   endtask

   ////////////////////////////////////////
   // Sampling and comparison
   ////////////////////////////////////////

   always @(posedge i_clock)
   begin
      seen_edge  <= 1'b1;
      last_instr <= i_instruction;
      last_reset <= i_soft_reset;
   end

   always @(negedge i_clock)
   begin
      #SAMPLE_DELAY;
      now_row = table_row(i_instruction);
      compare_value("o_reg_dst", 4'(now_row[11]), 4'(i_reg_dst), i_instruction);
      compare_value("o_reg_write", 4'(now_row[10]), 4'(i_reg_write), i_instruction);
      compare_value("o_alu_src", 4'(now_row[9]), 4'(i_alu_src), i_instruction);
      compare_value("o_mem_read", 4'(now_row[8]), 4'(i_mem_read), i_instruction);
      compare_value("o_mem_write", 4'(now_row[7]), 4'(i_mem_write), i_instruction);
      compare_value("o_mem_to_reg", 4'(now_row[6]), 4'(i_mem_to_reg), i_instruction);
      flag_checks++;
      if (seen_edge)
      begin
         if (!last_reset)
         begin
            compare_value("o_alu_op", 4'(ALUOP_MEM), 4'(i_alu_op), last_instr);
            compare_value("o_alu_ctrl", 4'(ALU_ADD), i_alu_ctrl, last_instr);
            reset_checks++;
         end
         else
         begin
            last_row = table_row(last_instr);   // One cycle behind
            compare_value("o_alu_op", 4'(last_row[5:4]), 4'(i_alu_op), last_instr);
            compare_value("o_alu_ctrl", last_row[3:0], i_alu_ctrl, last_instr);
            alu_checks++;
         end
      end
   end

   initial
   begin
      while (i_soft_reset !== 1'b1 && reset_wait < RESET_TIMEOUT)
      begin
         @(posedge i_clock);
         reset_wait++;
      end
      if (i_soft_reset !== 1'b1)
      begin
         $display("Reset was not released within %0d clock cycles", RESET_TIMEOUT);
         other_errors++;
      end
      else if (reset_checks == 0)
      begin
         $display("No ALU output was checked while reset was active");
         other_errors++;
      end
   end

endmodule

`default_nettype wire

// File: verilog/mips_control.sv
`default_nettype none

module mips_control
   import mips_control_pkg::*;
   (
      input  wire         i_clock,
      input  wire         i_soft_reset,
      input  wire instr_t i_instruction,
      output logic        o_reg_dst,
      output logic        o_reg_write,
      output logic        o_alu_src,
      output logic        o_mem_read,
      output logic        o_mem_write,
      output logic        o_mem_to_reg,
      output alu_op_t     o_alu_op,
      output alu_ctrl_t   o_alu_ctrl
   );

   alu_op_t dec_alu_op;     // Class of current instruction
   field_t  dec_op_field;   // Function or opcode for ALU stage

   ////////////////////////////////////////
   // Decode, flags leave in same cycle
   ////////////////////////////////////////

   main_decoder u_main_decoder (
      .i_instruction (i_instruction),
      .o_reg_dst     (o_reg_dst),
      .o_reg_write   (o_reg_write),
      .o_alu_src     (o_alu_src),
      .o_mem_read    (o_mem_read),
      .o_mem_write   (o_mem_write),
      .o_mem_to_reg  (o_mem_to_reg),
      .o_alu_op      (dec_alu_op),
      .o_op_field    (dec_op_field)
   );

   ////////////////////////////////////////
   // ALU stage, one cycle behind
   ////////////////////////////////////////

   alu_control u_alu_control (
      .i_clock      (i_clock),
      .i_soft_reset (i_soft_reset),
      .i_alu_op     (dec_alu_op),
      .i_op_field   (dec_op_field),
      .o_alu_op     (o_alu_op),
      .o_alu_ctrl   (o_alu_ctrl)
   );

endmodule

`default_nettype wire

// File: verilog/alu_control.sv
`default_nettype none

module alu_control
   import mips_control_pkg::*;
   (
      input  wire          i_clock,
      input  wire          i_soft_reset,
      input  wire alu_op_t i_alu_op,
      input  wire field_t  i_op_field,
      output alu_op_t      o_alu_op,
      output alu_ctrl_t    o_alu_ctrl
   );

   alu_op_t r_alu_op;
   field_t  r_op_field;

   ////////////////////////////////////////
   // Class and field registers
   ////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (!i_soft_reset)
      begin
         r_alu_op   <= ALUOP_MEM;   // Reads as ALU_ADD
         r_op_field <= '0;
      end
      else
      begin
         r_alu_op   <= i_alu_op;
         r_op_field <= i_op_field;
      end
   end

   assign o_alu_op = r_alu_op;

   ////////////////////////////////////////
   // ALU control code
   ////////////////////////////////////////

   always_comb
   begin
      case (r_alu_op)
         ALUOP_MEM:
         begin
            if (r_op_field == OP_LUI)
            begin
               o_alu_ctrl = ALU_LUI;
            end
            else
            begin
               o_alu_ctrl = ALU_ADD;   // Effective address
            end
         end
         ALUOP_BRANCH:
         begin
            o_alu_ctrl = ALU_SUB;
         end
         ALUOP_ARITH:
         begin
            // Function codes and immediate opcodes never overlap here
            case (r_op_field)
               FN_SLL, FN_SLLV:
                  o_alu_ctrl = ALU_SLL;
               FN_SRL, FN_SRLV:
                  o_alu_ctrl = ALU_SRL;
               FN_SRA, FN_SRAV:
                  o_alu_ctrl = ALU_SRA;
               FN_ADDU, OP_ADDI:
                  o_alu_ctrl = ALU_ADD;
               FN_SUBU:
                  o_alu_ctrl = ALU_SUB;
               FN_AND, OP_ANDI:
                  o_alu_ctrl = ALU_AND;
               FN_OR, OP_ORI:
                  o_alu_ctrl = ALU_OR;
               FN_XOR, OP_XORI:
                  o_alu_ctrl = ALU_XOR;
               FN_NOR:
                  o_alu_ctrl = ALU_NOR;
               FN_SLT, OP_SLTI:
                  o_alu_ctrl = ALU_SLT;
               default:
                  o_alu_ctrl = ALU_ADD;
            endcase
         end
         default:
         begin
            o_alu_ctrl = ALU_SUB;   // Class 11 unused
         end
      endcase
   end

   // The decoder upstream only ever produces the three defined classes
   a_class_defined: assert property (
      @(posedge i_clock) disable iff (!i_soft_reset)
      r_alu_op != 2'b11)
      else $error("alu_control: undefined ALU class registered");

endmodule

`default_nettype wire

// File: verilog/main_decoder.sv
`default_nettype none

module main_decoder
   import mips_control_pkg::*;
   (
      input  wire instr_t  i_instruction,
      output logic         o_reg_dst,
      output logic         o_reg_write,
      output logic         o_alu_src,
      output logic         o_mem_read,
      output logic         o_mem_write,
      output logic         o_mem_to_reg,
      output alu_op_t      o_alu_op,
      output field_t       o_op_field
   );

   field_t opcode;
   field_t funct;

   assign opcode = i_instruction[INSTR_W-1 -: OPCODE_W];
   assign funct  = i_instruction[FUNCT_W-1:0];

   ////////////////////////////////////////
   // Instruction table
   ////////////////////////////////////////

   always_comb
   begin
      o_reg_dst    = 1'b0;
      o_reg_write  = 1'b0;
      o_alu_src    = 1'b0;
      o_mem_read   = 1'b0;
      o_mem_write  = 1'b0;
      o_mem_to_reg = 1'b0;
      o_alu_op     = ALUOP_MEM;
      o_op_field   = opcode;   // Function code only for known R-type

      case (opcode)
         OP_RTYPE:
         begin
            case (funct)
               FN_SLL, FN_SRL, FN_SRA:
               begin
                  o_reg_dst   = 1'b1;
                  o_reg_write = 1'b1;
                  o_alu_src   = 1'b1;   // Shift amount from shamt
                  o_alu_op    = ALUOP_ARITH;
                  o_op_field  = funct;
               end
               FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU, FN_SUBU,
               FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT:
               begin
                  o_reg_dst   = 1'b1;
                  o_reg_write = 1'b1;
                  o_alu_op    = ALUOP_ARITH;
                  o_op_field  = funct;
               end
               FN_JR:
               begin
                  o_alu_op   = ALUOP_BRANCH;
                  o_op_field = funct;
               end
               FN_JALR:
               begin
                  o_reg_dst   = 1'b1;   // Link into rd
                  o_reg_write = 1'b1;
                  o_alu_op    = ALUOP_BRANCH;
                  o_op_field  = funct;
               end
               default:
               begin
                  o_op_field = OP_RTYPE;   // Unknown function, all low
               end
            endcase
         end
         OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU:
         begin
            o_reg_write  = 1'b1;
            o_alu_src    = 1'b1;
            o_mem_read   = 1'b1;
            o_mem_to_reg = 1'b1;
         end
         OP_SB, OP_SH, OP_SW:
         begin
            o_alu_src   = 1'b1;
            o_mem_write = 1'b1;
         end
         OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI:
         begin
            o_reg_write = 1'b1;
            o_alu_src   = 1'b1;
            o_alu_op    = ALUOP_ARITH;
         end
         OP_LUI:
         begin
            o_reg_write = 1'b1;
            o_alu_src   = 1'b1;   // Stays in MEM class
         end
         OP_BEQ, OP_BNE:
         begin
            o_alu_src = 1'b1;
            o_alu_op  = ALUOP_BRANCH;
         end
         OP_J:
         begin
            o_alu_op = ALUOP_BRANCH;
         end
         OP_JAL:
         begin
            o_reg_write = 1'b1;   // Link into r31
            o_alu_op    = ALUOP_BRANCH;
         end
         default:
         begin
            o_alu_op = ALUOP_MEM;   // Unknown opcode
         end
      endcase

      // No row of the table may read and write memory at once
      assert (!(o_mem_read && o_mem_write))
         else $error("main_decoder: memory read and write both set");
   end

endmodule

`default_nettype wire

// File: verilog/mips_control_pkg.sv
`default_nettype none

package mips_control_pkg;

   ////////////////////////////////////////
   // Field widths
   ////////////////////////////////////////

   localparam int INSTR_W  = 32;
   localparam int OPCODE_W = 6;   // Bits 31..26
   localparam int FUNCT_W  = 6;   // Bits 5..0

   typedef logic [INSTR_W-1:0]  instr_t;
   typedef logic [OPCODE_W-1:0] field_t;   // Opcode or function value

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   localparam field_t OP_RTYPE = 6'd0;    // Decoded by function field
   localparam field_t OP_J     = 6'd2;
   localparam field_t OP_JAL   = 6'd3;
   localparam field_t OP_BEQ   = 6'd4;
   localparam field_t OP_BNE   = 6'd5;
   localparam field_t OP_ADDI  = 6'd8;
   localparam field_t OP_SLTI  = 6'd10;
   localparam field_t OP_ANDI  = 6'd12;
   localparam field_t OP_ORI   = 6'd13;
   localparam field_t OP_XORI  = 6'd14;
   localparam field_t OP_LUI   = 6'd15;
   localparam field_t OP_LB    = 6'd32;
   localparam field_t OP_LH    = 6'd33;
   localparam field_t OP_LW    = 6'd35;
   localparam field_t OP_LBU   = 6'd36;
   localparam field_t OP_LHU   = 6'd37;
   localparam field_t OP_LWU   = 6'd39;
   localparam field_t OP_SB    = 6'd40;
   localparam field_t OP_SH    = 6'd41;
   localparam field_t OP_SW    = 6'd43;

   ////////////////////////////////////////
   // R-type function codes
   ////////////////////////////////////////

   localparam field_t FN_SLL  = 6'd0;
   localparam field_t FN_SRL  = 6'd2;
   localparam field_t FN_SRA  = 6'd3;
   localparam field_t FN_SLLV = 6'd4;
   localparam field_t FN_SRLV = 6'd6;
   localparam field_t FN_SRAV = 6'd7;
   localparam field_t FN_JR   = 6'd8;
   localparam field_t FN_JALR = 6'd9;
   localparam field_t FN_ADDU = 6'd33;
   localparam field_t FN_SUBU = 6'd35;
   localparam field_t FN_AND  = 6'd36;
   localparam field_t FN_OR   = 6'd37;
   localparam field_t FN_XOR  = 6'd38;
   localparam field_t FN_NOR  = 6'd39;
   localparam field_t FN_SLT  = 6'd42;

   ////////////////////////////////////////
   // ALU class and ALU control code
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      ALUOP_MEM    = 2'b00,   // Address or LUI
      ALUOP_BRANCH = 2'b01,   // Compare or jump
      ALUOP_ARITH  = 2'b10    // Selected by field
   } alu_op_t;

   typedef enum logic [3:0] {
      ALU_AND = 4'b0000,
      ALU_OR  = 4'b0001,
      ALU_ADD = 4'b0010,
      ALU_SUB = 4'b0110,
      ALU_SLT = 4'b0111,
      ALU_LUI = 4'b1000,
      ALU_XOR = 4'b1001,
      ALU_NOR = 4'b1010,
      ALU_SLL = 4'b1011,
      ALU_SRL = 4'b1100,
      ALU_SRA = 4'b1101
   } alu_ctrl_t;

endpackage

`default_nettype wire
